/* design/download_decoder.sv */
// Download decoder producing download-type flags, the EXE launch pulse and core reset
`timescale 1ns/1ps
`include "loader_consts.svh"

module download_decoder (
	input  logic                  clk_1x,
	input  logic                  arst_n,
	input  logic                  ioctl_download,
	input  loader_pkg::dl_index_t ioctl_index,
	input  logic                  reset_req,
	output logic                  bios_dl,
	output logic                  exe_dl,
	output logic                  cd_dl,
	output logic                  load_exe,
	output logic                  core_reset
);

	import loader_pkg::*;

	// Previous EXE flag for falling edge detection
	logic exe_dl_q;

	// =====================================================================
	// Download type flags
	// =====================================================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			bios_dl  <= 1'b0;
			exe_dl   <= 1'b0;
			cd_dl    <= 1'b0;
			exe_dl_q <= 1'b0;
			load_exe <= 1'b0;
		end else begin
			bios_dl <= ioctl_download && (ioctl_index == dl_index_t'(`LDR_IDX_BIOS));
			exe_dl  <= ioctl_download && (ioctl_index == dl_index_t'(`LDR_IDX_EXE));
			// Upper index bits carry the drive number
			cd_dl   <= ioctl_download &&
				(ioctl_index[`LDR_CD_IDX_BITS-1:0] == `LDR_CD_IDX_BITS'(`LDR_IDX_CD));

			// Launch once the executable image is complete
			exe_dl_q <= exe_dl;
			load_exe <= exe_dl_q && !exe_dl;
		end
	end

	// Core held in reset while any image is loading
	assign core_reset = reset_req | bios_dl | exe_dl | cd_dl;

endmodule

/* design/download_writer.sv */
// Download writer packing host halves into RAM words and sharing the RAM write port
`timescale 1ns/1ps
`include "loader_consts.svh"

module download_writer (
	input  logic                  clk_1x,
	input  logic                  arst_n,
	input  logic                  bios_dl,
	input  logic                  exe_dl,
	input  logic                  ioctl_wr,
	input  loader_pkg::dl_addr_t  ioctl_addr,
	input  loader_pkg::half_t     ioctl_dout,
	input  logic                  ram_write_ack,
	input  logic                  core_req,
	input  logic                  core_rnw,
	input  loader_pkg::ram_addr_t core_addr,
	input  loader_pkg::ram_word_t core_din,
	input  loader_pkg::byte_en_t  core_be,
	output logic                  ioctl_wait,
	output logic                  ram_wr,
	output loader_pkg::ram_addr_t ram_addr,
	output loader_pkg::ram_word_t ram_din,
	output loader_pkg::byte_en_t  ram_be
);

	import loader_pkg::*;

	// Download owns the RAM port
	logic      dl_active;

	// Region base and offset byte address
	dl_addr_t  region_base;
	dl_addr_t  offset_addr;

	// Assembled word and its target
	ram_word_t dl_data;
	ram_addr_t dl_addr;
	logic      dl_wr;

	assign dl_active = bios_dl | exe_dl;

	// Only BIOS and EXE images go to RAM
	assign region_base = bios_dl ? dl_addr_t'(`LDR_BIOS_BASE) : dl_addr_t'(`LDR_EXE_BASE);
	assign offset_addr = ioctl_addr + region_base;

	// =====================================================================
	// Half-word packing and host wait
	// =====================================================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			dl_data    <= '0;
			dl_addr    <= '0;
			dl_wr      <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			dl_wr <= 1'b0;
			if (dl_active) begin
				// Release the host once RAM has taken the word
				if (ram_write_ack) begin
					ioctl_wait <= 1'b0;
				end
				if (ioctl_wr) begin
					if (!ioctl_addr[1]) begin
						// Low half also fixes the word address
						dl_data[15:0] <= ioctl_dout;
						dl_addr       <= offset_addr[$bits(ram_addr_t)-1:0];
					end else begin
						// High half completes the word
						dl_data[31:16] <= ioctl_dout;
						dl_wr          <= 1'b1;
						ioctl_wait     <= 1'b1;
					end
				end
			end else begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// =====================================================================
	// RAM write port select
	// =====================================================================

	always_comb begin
		if (dl_active) begin
			ram_wr   = dl_wr;
			ram_addr = dl_addr;
			ram_din  = dl_data;
			ram_be   = '1;
		end else begin
			// Core reads never reach the write port
			ram_wr   = core_req & ~core_rnw;
			ram_addr = core_addr;
			ram_din  = core_din;
			ram_be   = core_be;
		end
	end

endmodule

/* design/loader_consts.svh */
// Loader constants for download indices, RAM region bases and mount slots
`ifndef LOADER_CONSTS_SVH
`define LOADER_CONSTS_SVH

// =========================================================================
// Host download indices
// =========================================================================

`define LDR_IDX_BIOS 0
`define LDR_IDX_EXE 1
`define LDR_IDX_CD 2

// CD index matches on the low bits only
`define LDR_CD_IDX_BITS 6

// =========================================================================
// RAM region bases as byte offsets added to the host address
// =========================================================================

`define LDR_BIOS_BASE 2097152
`define LDR_EXE_BASE 4194304

// Block device mount slots
`define LDR_SLOT_CD 1
`define LDR_SLOT_CARD1 2
`define LDR_SLOT_CARD2 3

`endif

/* design/loader_pkg.sv */
// Loader package with the vector types shared by the download and media blocks
package loader_pkg;

	// Host download index
	typedef logic [7:0] dl_index_t;

	// Host byte address
	typedef logic [26:0] dl_addr_t;

	// One 16-bit download half
	typedef logic [15:0] half_t;

	// RAM data word
	typedef logic [31:0] ram_word_t;

	// RAM address that download addresses are cut down to
	typedef logic [22:0] ram_addr_t;

	// RAM byte enables
	typedef logic [3:0] byte_en_t;

	// Image size reported on mount
	typedef logic [63:0] img_size_t;

	// Stored CD size
	typedef logic [29:0] cd_size_t;

	// One mount strobe per block device slot
	typedef logic [3:0] mount_vec_t;

endpackage

/* design/loader_top.sv */
// Loader top level joining the download decoder, RAM writer and media tracker
`timescale 1ns/1ps

module loader_top (
	input  logic                   clk_1x,
	input  logic                   arst_n,
	// Host download
	input  logic                   ioctl_download,
	input  loader_pkg::dl_index_t  ioctl_index,
	input  logic                   ioctl_wr,
	input  loader_pkg::dl_addr_t   ioctl_addr,
	input  loader_pkg::half_t      ioctl_dout,
	output logic                   ioctl_wait,
	input  logic                   reset_req,
	// Core write request
	input  logic                   core_req,
	input  logic                   core_rnw,
	input  loader_pkg::ram_addr_t  core_addr,
	input  loader_pkg::ram_word_t  core_din,
	input  loader_pkg::byte_en_t   core_be,
	// RAM write port
	output logic                   ram_wr,
	output loader_pkg::ram_addr_t  ram_addr,
	output loader_pkg::ram_word_t  ram_din,
	output loader_pkg::byte_en_t   ram_be,
	input  logic                   ram_write_ack,
	// Mounts and menu requests
	input  loader_pkg::mount_vec_t img_mounted,
	input  loader_pkg::img_size_t  img_size,
	input  logic                   card_load_req,
	input  logic                   card_save_req,
	input  logic                   card_autosave,
	input  logic                   osd_status,
	// Media state and core control
	output logic                   has_cd,
	output logic                   cd_hps_on,
	output loader_pkg::cd_size_t   cd_size,
	output logic                   card1_mounted,
	output logic                   card2_mounted,
	output logic                   card1_load,
	output logic                   card2_load,
	output logic                   card_save,
	output logic                   media_loaded,
	output logic                   load_exe,
	output logic                   core_reset
);

	// Download type flags
	logic bios_dl;
	logic exe_dl;
	logic cd_dl;

	download_decoder decoder_i (
		.clk_1x         (clk_1x),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.reset_req      (reset_req),
		.bios_dl        (bios_dl),
		.exe_dl         (exe_dl),
		.cd_dl          (cd_dl),
		.load_exe       (load_exe),
		.core_reset     (core_reset)
	);

	download_writer writer_i (
		.clk_1x        (clk_1x),
		.arst_n        (arst_n),
		.bios_dl       (bios_dl),
		.exe_dl        (exe_dl),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.ram_write_ack (ram_write_ack),
		.core_req      (core_req),
		.core_rnw      (core_rnw),
		.core_addr     (core_addr),
		.core_din      (core_din),
		.core_be       (core_be),
		.ioctl_wait    (ioctl_wait),
		.ram_wr        (ram_wr),
		.ram_addr      (ram_addr),
		.ram_din       (ram_din),
		.ram_be        (ram_be)
	);

	media_tracker tracker_i (
		.clk_1x        (clk_1x),
		.arst_n        (arst_n),
		.exe_dl        (exe_dl),
		.cd_dl         (cd_dl),
		.ioctl_addr    (ioctl_addr),
		.img_mounted   (img_mounted),
		.img_size      (img_size),
		.card_load_req (card_load_req),
		.card_save_req (card_save_req),
		.card_autosave (card_autosave),
		.osd_status    (osd_status),
		.has_cd        (has_cd),
		.cd_hps_on     (cd_hps_on),
		.cd_size       (cd_size),
		.card1_mounted (card1_mounted),
		.card2_mounted (card2_mounted),
		.card1_load    (card1_load),
		.card2_load    (card2_load),
		.card_save     (card_save),
		.media_loaded  (media_loaded)
	);

endmodule

/* design/media_tracker.sv */
// Media tracker for CD and memory card state with menu load and save pulses
`timescale 1ns/1ps
`include "loader_consts.svh"

module media_tracker (
	input  logic                   clk_1x,
	input  logic                   arst_n,
	input  logic                   exe_dl,
	input  logic                   cd_dl,
	input  loader_pkg::dl_addr_t   ioctl_addr,
	input  loader_pkg::mount_vec_t img_mounted,
	input  loader_pkg::img_size_t  img_size,
	input  logic                   card_load_req,
	input  logic                   card_save_req,
	input  logic                   card_autosave,
	input  logic                   osd_status,
	output logic                   has_cd,
	output logic                   cd_hps_on,
	output loader_pkg::cd_size_t   cd_size,
	output logic                   card1_mounted,
	output logic                   card2_mounted,
	output logic                   card1_load,
	output logic                   card2_load,
	output logic                   card_save,
	output logic                   media_loaded
);

	import loader_pkg::*;

	logic img_nonzero;
	logic autosave_req;

	// Previous values for edge detection
	logic cd_dl_q;
	logic load_req_q;
	logic save_req_q;
	logic autosave_q;

	assign img_nonzero  = (img_size != '0);

	// Autosave only fires while the menu is open
	assign autosave_req = card_autosave & osd_status;

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			has_cd        <= 1'b0;
			cd_hps_on     <= 1'b0;
			cd_size       <= '0;
			card1_mounted <= 1'b0;
			card2_mounted <= 1'b0;
			card1_load    <= 1'b0;
			card2_load    <= 1'b0;
			card_save     <= 1'b0;
			media_loaded  <= 1'b0;
			cd_dl_q       <= 1'b0;
			load_req_q    <= 1'b0;
			save_req_q    <= 1'b0;
			autosave_q    <= 1'b0;
		end else begin
			cd_dl_q    <= cd_dl;
			load_req_q <= card_load_req;
			save_req_q <= card_save_req;
			autosave_q <= autosave_req;

			// ==============================================================
			// CD state
			// ==============================================================

			// Size from the final byte address when a direct download ends
			if (cd_dl_q && !cd_dl) begin
				cd_size   <= cd_size_t'(ioctl_addr);
				cd_hps_on <= 1'b0;
				has_cd    <= 1'b1;
			end
			// A block device mount takes priority
			if (img_mounted[`LDR_SLOT_CD]) begin
				if (img_nonzero) begin
					cd_size   <= img_size[$bits(cd_size_t)-1:0];
					cd_hps_on <= 1'b1;
					has_cd    <= 1'b1;
				end else begin
					has_cd <= 1'b0;
				end
			end

			// ==============================================================
			// Memory cards
			// ==============================================================

			card1_load <= 1'b0;
			card2_load <= 1'b0;
			card_save  <= 1'b0;

			if (img_mounted[`LDR_SLOT_CARD1]) begin
				card1_mounted <= img_nonzero;
				card1_load    <= img_nonzero;
			end
			if (img_mounted[`LDR_SLOT_CARD2]) begin
				card2_mounted <= img_nonzero;
				card2_load    <= img_nonzero;
			end

			// Menu reload hits both cards
			if (card_load_req && !load_req_q) begin
				card1_load <= 1'b1;
				card2_load <= 1'b1;
			end
			if ((card_save_req && !save_req_q) || (autosave_req && !autosave_q)) begin
				card_save <= 1'b1;
			end

			// Sticky until reset
			if (exe_dl || cd_dl || img_mounted[`LDR_SLOT_CD]) begin
				media_loaded <= 1'b1;
			end
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the loader testbench with Verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f tb.f --top-module tb_loader_top -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Errors found" sim.log; then
	echo "Simulation failed"
	exit 1
fi

if ! grep -q "No errors" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi

echo "Simulation passed"

/* tb.f */
+incdir+design
design/loader_pkg.sv
design/download_decoder.sv
design/download_writer.sv
design/media_tracker.sv
design/loader_top.sv
tests/tb_loader_top.sv

/* tests/tb_loader_top.sv */
// Testbench for the loader top level with a RAM ack model, scoreboard and assertions
`timescale 1ns/1ps
`include "loader_consts.svh"

module tb_loader_top;

	import loader_pkg::*;

	localparam int BIOS_WORDS  = 8;
	localparam int EXE_WORDS   = 6;
	localparam int WORD_CYCLES = 16;
	localparam int WAIT_LIMIT  = 20;
	// Reset, both downloads, five short tests of about 40 cycles, then margin
	localparam int RUN_CYCLES  = 16 + (BIOS_WORDS + EXE_WORDS + 4) * WORD_CYCLES + 5 * 40 + 100;
	localparam int WATCHDOG_NS = RUN_CYCLES * 100;

	logic       clk_1x = 1'b0;
	logic       arst_n;
	logic       ioctl_download, ioctl_wr, ioctl_wait, reset_req;
	dl_index_t  ioctl_index;
	dl_addr_t   ioctl_addr;
	half_t      ioctl_dout;
	logic       core_req, core_rnw;
	ram_addr_t  core_addr;
	ram_word_t  core_din;
	byte_en_t   core_be;
	logic       ram_wr, ram_write_ack;
	ram_addr_t  ram_addr;
	ram_word_t  ram_din;
	byte_en_t   ram_be;
	mount_vec_t img_mounted;
	img_size_t  img_size;
	logic       card_load_req, card_save_req, card_autosave, osd_status;
	logic       has_cd, cd_hps_on, card1_mounted, card2_mounted;
	logic       card1_load, card2_load, card_save, media_loaded, load_exe, core_reset;
	cd_size_t   cd_size;

	logic [31:0] lfsr_state = 32'h21a8;
	int          err_count  = 0;
	int          test_base  = 0;
	int          tests_run  = 0;

	// Scoreboard of packed words the host has sent
	ram_addr_t   want_addr_q[$];
	ram_word_t   want_data_q[$];

	loader_top dut_i (.*);

	always #50 clk_1x = ~clk_1x;

	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	task automatic report_value(input string name, input logic [63:0] got,
		input logic [63:0] want);
		$display("** Error: %s = %h, expected %h at %0t", name, got, want, $time);
		err_count++;
	endtask

	task automatic report_bit(input string name, input logic got);
		$display("** Error: %s = %h, expected %h at %0t", name, got, !got, $time);
		err_count++;
	endtask

	task automatic end_test(input string name);
		$display("Test %s finished with %0d errors", name, err_count - test_base);
		test_base = err_count;
		tests_run++;
	endtask

	// Inputs change 10 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_1x);
		#10;
	endtask

	task automatic wait_host_release();
		int waited;
		waited = 0;
		while (ioctl_wait && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (ioctl_wait) begin
			$display("Host wait still high after %0d cycles at %0t", WAIT_LIMIT, $time);
			err_count++;
		end
	endtask

	task automatic send_half(input dl_addr_t addr, input half_t data);
		wait_host_release();
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		next_cycle();
		ioctl_wr   = 1'b0;
	endtask

	task automatic send_word(input dl_addr_t addr, input dl_addr_t base);
		half_t lo;
		half_t hi;
		lo = half_t'(rand_bits(16));
		hi = half_t'(rand_bits(16));
		want_addr_q.push_back(ram_addr_t'(addr + base));
		want_data_q.push_back({hi, lo});
		send_half(addr, lo);
		send_half(addr + dl_addr_t'(2), hi);
	endtask

	task automatic run_download(input dl_index_t index, input dl_addr_t base, input int words);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		next_cycle();
		for (int i = 0; i < words; i++) begin
			send_word(dl_addr_t'(i * 4), base);
		end
		wait_host_release();
		ioctl_download = 1'b0;
		// Room for the launch pulse
		repeat (4) next_cycle();
		if (want_addr_q.size() != 0) begin
			$display("%0d expected RAM writes never arrived", want_addr_q.size());
			err_count++;
			want_addr_q.delete();
			want_data_q.delete();
		end
	endtask

	task automatic mount_image(input mount_vec_t slots, input img_size_t size);
		img_size    = size;
		img_mounted = slots;
		next_cycle();
		img_mounted = '0;
		repeat (2) next_cycle();
	endtask

	// =========================================================================
	// RAM model acking each download write 1 to 6 cycles later
	// =========================================================================

	initial begin : ram_model
		ram_addr_t want_addr;
		ram_word_t want_data;
		int        delay;
		ram_write_ack = 1'b0;
		forever begin
			@(negedge clk_1x);
			if (arst_n && ram_wr && !core_req) begin
				if (want_addr_q.size() == 0) begin
					$display("RAM write at %0t matches no host word", $time);
					err_count++;
				end else begin
					want_addr = want_addr_q.pop_front();
					want_data = want_data_q.pop_front();
					a_ram_word: assert ({ram_addr, ram_din, ram_be} ==
						{want_addr, want_data, 4'hf})
						else report_value("ram_addr/ram_din/ram_be",
							64'({ram_addr, ram_din, ram_be}), 64'({want_addr, want_data, 4'hf}));
				end
				delay = 1 + int'(rand_bits(3) % 6);
				repeat (delay) @(posedge clk_1x);
				#10;
				ram_write_ack = 1'b1;
				@(posedge clk_1x);
				#10;
				ram_write_ack = 1'b0;
			end
		end
	end

	// =========================================================================
	// Assertions
	// =========================================================================

	a_wait_rise: assert property (@(posedge clk_1x) disable iff (!arst_n)
		ram_wr && !core_req |-> ioctl_wait)
		else report_bit("ioctl_wait", $sampled(ioctl_wait));
	a_wait_hold: assert property (@(posedge clk_1x) disable iff (!arst_n)
		ioctl_wait && !ram_write_ack |=> ioctl_wait)
		else report_bit("ioctl_wait", $sampled(ioctl_wait));
	a_wait_drop: assert property (@(posedge clk_1x) disable iff (!arst_n)
		ram_write_ack |=> !ioctl_wait) else report_bit("ioctl_wait", $sampled(ioctl_wait));
	// One RAM write per packed word
	a_wr_once: assert property (@(posedge clk_1x) disable iff (!arst_n)
		ioctl_wait && $past(ioctl_wait) |-> !ram_wr)
		else report_bit("ram_wr", $sampled(ram_wr));
	a_wait_idle: assert property (@(posedge clk_1x) disable iff (!arst_n)
		!core_reset |=> !ioctl_wait) else report_bit("ioctl_wait", $sampled(ioctl_wait));
	a_dl_reset: assert property (@(posedge clk_1x) disable iff (!arst_n)
		ioctl_download |=> core_reset) else report_bit("core_reset", $sampled(core_reset));
	a_req_reset: assert property (@(posedge clk_1x) disable iff (!arst_n)
		reset_req |-> core_reset) else report_bit("core_reset", $sampled(core_reset));
	a_core_wr: assert property (@(posedge clk_1x) disable iff (!arst_n)
		!core_reset |-> ram_wr == (core_req && !core_rnw))
		else report_bit("ram_wr", $sampled(ram_wr));
	a_core_bus: assert property (@(posedge clk_1x) disable iff (!arst_n)
		!core_reset && ram_wr |-> {ram_addr, ram_din, ram_be} == {core_addr, core_din, core_be})
		else report_value("ram_addr/ram_din/ram_be",
			64'($sampled({ram_addr, ram_din, ram_be})),
			64'($sampled({core_addr, core_din, core_be})));
	// Flag one cycle, edge one more, then the pulse register
	a_load_exe: assert property (@(posedge clk_1x) disable iff (!arst_n)
		load_exe == ($past(ioctl_download, 3) && !$past(ioctl_download, 2) &&
		$past(ioctl_index, 3) == dl_index_t'(`LDR_IDX_EXE)))
		else report_bit("load_exe", $sampled(load_exe));
	a_media_set: assert property (@(posedge clk_1x) disable iff (!arst_n)
		$past(ioctl_download) && ($past(ioctl_index) == dl_index_t'(`LDR_IDX_EXE) ||
		$past(ioctl_index) == dl_index_t'(`LDR_IDX_CD)) |=> media_loaded)
		else report_bit("media_loaded", $sampled(media_loaded));
	a_media_hold: assert property (@(posedge clk_1x) disable iff (!arst_n)
		media_loaded |=> media_loaded)
		else report_bit("media_loaded", $sampled(media_loaded));
	a_cd_end: assert property (@(posedge clk_1x) disable iff (!arst_n)
		$past(ioctl_download, 3) && !$past(ioctl_download, 2) &&
		$past(ioctl_index, 3) == dl_index_t'(`LDR_IDX_CD) |->
		{cd_size, has_cd, cd_hps_on} == {cd_size_t'(ioctl_addr), 2'b10})
		else report_value("cd_size/has_cd/cd_hps_on",
			64'($sampled({cd_size, has_cd, cd_hps_on})),
			64'({cd_size_t'(ioctl_addr), 2'b10}));
	a_cd_mount: assert property (@(posedge clk_1x) disable iff (!arst_n)
		img_mounted[`LDR_SLOT_CD] && img_size != '0 |=>
		{cd_size, has_cd, cd_hps_on} == {cd_size_t'(img_size), 2'b11})
		else report_value("cd_size/has_cd/cd_hps_on",
			64'($sampled({cd_size, has_cd, cd_hps_on})),
			64'({cd_size_t'(img_size), 2'b11}));
	a_cd_eject: assert property (@(posedge clk_1x) disable iff (!arst_n)
		img_mounted[`LDR_SLOT_CD] && img_size == '0 |=> !has_cd)
		else report_bit("has_cd", $sampled(has_cd));
	a_card1_present: assert property (@(posedge clk_1x) disable iff (!arst_n)
		img_mounted[`LDR_SLOT_CARD1] |=> card1_mounted == (img_size != '0))
		else report_bit("card1_mounted", $sampled(card1_mounted));
	a_card2_present: assert property (@(posedge clk_1x) disable iff (!arst_n)
		img_mounted[`LDR_SLOT_CARD2] |=> card2_mounted == (img_size != '0))
		else report_bit("card2_mounted", $sampled(card2_mounted));
	a_card1_load: assert property (@(posedge clk_1x) disable iff (!arst_n)
		card1_load == ($past(img_mounted[`LDR_SLOT_CARD1] && img_size != '0) ||
		($past(card_load_req) && !$past(card_load_req, 2))))
		else report_bit("card1_load", $sampled(card1_load));
	a_card2_load: assert property (@(posedge clk_1x) disable iff (!arst_n)
		card2_load == ($past(img_mounted[`LDR_SLOT_CARD2] && img_size != '0) ||
		($past(card_load_req) && !$past(card_load_req, 2))))
		else report_bit("card2_load", $sampled(card2_load));
	a_card_save: assert property (@(posedge clk_1x) disable iff (!arst_n)
		card_save == (($past(card_save_req) && !$past(card_save_req, 2)) ||
		($past(card_autosave && osd_status) && !$past(card_autosave && osd_status, 2))))
		else report_bit("card_save", $sampled(card_save));

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog timeout after %0d ns, tests did not complete", WATCHDOG_NS);
		$display("Errors found");
		$finish;
	end

	// =========================================================================
	// Stimulus
	// =========================================================================

	initial begin : stimulus
		arst_n         = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		reset_req      = 1'b0;
		core_req       = 1'b0;
		core_rnw       = 1'b1;
		core_addr      = '0;
		core_din       = '0;
		core_be        = '0;
		img_mounted    = '0;
		img_size       = '0;
		card_load_req  = 1'b0;
		card_save_req  = 1'b0;
		card_autosave  = 1'b0;
		osd_status     = 1'b0;
		repeat (16) @(posedge clk_1x);
		#10;
		arst_n = 1'b1;
		next_cycle();

		run_download(dl_index_t'(`LDR_IDX_BIOS), dl_addr_t'(`LDR_BIOS_BASE), BIOS_WORDS);
		end_test("bios_download");
		run_download(dl_index_t'(`LDR_IDX_EXE), dl_addr_t'(`LDR_EXE_BASE), EXE_WORDS);
		end_test("exe_download");

		// Writes on even steps, reads on odd, one idle step
		for (int i = 0; i < 8; i++) begin
			core_req  = (i != 6);
			core_rnw  = i[0];
			core_addr = ram_addr_t'(rand_bits(23));
			core_din  = rand_bits(32);
			core_be   = byte_en_t'(rand_bits(4));
			next_cycle();
		end
		core_req = 1'b0;
		repeat (2) next_cycle();
		end_test("core_passthrough");

		// CD halves never reach RAM, only the final address counts
		ioctl_index    = dl_index_t'(`LDR_IDX_CD);
		ioctl_download = 1'b1;
		next_cycle();
		for (int i = 0; i < 3; i++) begin
			send_half(dl_addr_t'(27'h100 + i * 2), half_t'(rand_bits(16)));
		end
		ioctl_download = 1'b0;
		repeat (4) next_cycle();
		mount_image(mount_vec_t'(1 << `LDR_SLOT_CD), img_size_t'(64'h1234_5678));
		mount_image(mount_vec_t'(1 << `LDR_SLOT_CD), '0);
		end_test("cd_tracking");

		mount_image(mount_vec_t'(1 << `LDR_SLOT_CARD1), img_size_t'(64'h2_0000));
		mount_image(mount_vec_t'(1 << `LDR_SLOT_CARD2), img_size_t'(64'h2_0000));
		card_load_req = 1'b1;
		repeat (4) next_cycle();
		card_load_req = 1'b0;
		card_save_req = 1'b1;
		repeat (3) next_cycle();
		card_save_req = 1'b0;
		osd_status    = 1'b1;
		card_autosave = 1'b1;
		repeat (3) next_cycle();
		card_autosave = 1'b0;
		osd_status    = 1'b0;
		mount_image(mount_vec_t'(1 << `LDR_SLOT_CARD1), '0);
		end_test("memory_cards");

		reset_req = 1'b1;
		next_cycle();
		reset_req = 1'b0;
		run_download(dl_index_t'(`LDR_IDX_EXE), dl_addr_t'(`LDR_EXE_BASE), 2);
		run_download(dl_index_t'(`LDR_IDX_BIOS), dl_addr_t'(`LDR_BIOS_BASE), 2);
		arst_n = 1'b0;
		next_cycle();
		a_media_clear: assert (!media_loaded) else report_bit("media_loaded", media_loaded);
		arst_n = 1'b1;
		next_cycle();
		end_test("reset_sticky");

		$display("Tests run: %0d, errors: %0d", tests_run, err_count);
		if (err_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
